// File: files.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/burst_bus_if.sv
hdl/icache.sv
hdl/burst_ram.sv
hdl/icache_top.sv
dv/icache_tb.sv

// File: dv/icache_tb.sv
/*
 * icache subsystem testbench, preloads a random program image and runs
 * directed and random fetches against a direct-mapped reference model
 */
`default_nettype none

`include "icache_consts.svh"

module icache_tb;

  localparam int clk_period = 100;
  localparam int rows = 1 << `BRAM_DEPTH_W;
  // worst case miss with an idle memory
  localparam int max_miss = `BRAM_LATENCY + `BRAM_BURST_LEN + 2;
  // upper bound on fetches issued over all tests
  localparam int num_requests = 220;
  localparam int watchdog_cycles = num_requests * 2 * max_miss + rows + 32;

  logic        clk;
  logic        rst;
  logic        req;
  logic [31:0] addr;
  logic [31:0] data;
  logic        data_ready;
  logic        busy;
  logic [31:0] hit_count;
  logic [31:0] miss_count;
  logic        load_en;
  logic [7:0]  load_addr;
  logic [63:0] load_data;

  // shadow of the memory image and of the cache tags
  logic [63:0] shadow_mem [rows];
  logic [25:0] shadow_tag [2];
  logic [1:0]  shadow_valid;
  logic [31:0] exp_q [$];
  logic [31:0] popped;
  int          exp_hits;
  int          exp_misses;
  // request raised during the next miss, must be ignored
  logic        stray_en;
  logic [31:0] stray_addr;
  integer      seed;
  int          errors;
  int          errors_before;
  int          passed;
  int          failed;
  int          test_num;

  icache_top UUT (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .addr       (addr),
    .data       (data),
    .data_ready (data_ready),
    .busy       (busy),
    .hit_count  (hit_count),
    .miss_count (miss_count),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  always #50 clk = ~clk;

  // expected word and hit flag, a miss takes over the line
  function automatic logic [31:0] model_fetch(input logic [31:0] a, output bit hit);
    logic [63:0] row;
    logic        line;
    row = shadow_mem[a[10:3]];
    line = a[5];
    hit = shadow_valid[line] && (shadow_tag[line] == a[31:6]);
    if (!hit) begin
      shadow_tag[line] = a[31:6];
      shadow_valid[line] = 1'b1;
    end
    return a[2] ? row[63:32] : row[31:0];
  endfunction

  // every data_ready pulse consumes one expected word
  always @(negedge clk) begin
    if (!rst && data_ready === 1'b1) begin
      assert (exp_q.size() > 0) else begin
        $display("data_ready pulsed at %0t with no fetch outstanding", $time);
        errors++;
      end
      if (exp_q.size() > 0) begin
        popped = exp_q.pop_front();
        assert (data === popped) else begin
          $display("Error at %0t: data expected %h, got %h", $time, popped, data);
          errors++;
        end
      end
    end
  end

  task automatic check_counters();
    assert (hit_count === exp_hits) else begin
      $display("Error at %0t: hit_count expected %0d, got %0d", $time, exp_hits, hit_count);
      errors++;
    end
    assert (miss_count === exp_misses) else begin
      $display("Error at %0t: miss_count expected %0d, got %0d", $time, exp_misses,
               miss_count);
      errors++;
    end
  endtask

  // called on a falling edge with busy low, returns once the cache is idle
  task automatic fetch(input logic [31:0] a);
    bit          hit;
    logic [31:0] w;
    int          n;
    w = model_fetch(a, hit);
    exp_q.push_back(w);
    if (hit) exp_hits++;
    else exp_misses++;
    req = 1'b1;
    addr = a;
    @(negedge clk);
    req = 1'b0;
    if (hit) begin
      // hit answers in the very next cycle, busy stays low
      assert (data_ready === 1'b1) else begin
        $display("Error at %0t: data_ready expected 1, got %b", $time, data_ready);
        errors++;
      end
      assert (busy === 1'b0) else begin
        $display("Error at %0t: busy expected 0, got %b", $time, busy);
        errors++;
      end
    end else begin
      assert (busy === 1'b1) else begin
        $display("Error at %0t: busy expected 1, got %b", $time, busy);
        errors++;
      end
      n = 0;
      if (stray_en) begin
        // second request while the fill runs
        req = 1'b1;
        addr = stray_addr;
        repeat (2) @(negedge clk);
        req = 1'b0;
        n = 2;
      end
      while (busy === 1'b1 && n < max_miss) begin
        @(negedge clk);
        n++;
      end
      assert (busy === 1'b0) else begin
        $display("miss at %h did not finish within %0d cycles", a, max_miss);
        errors++;
      end
    end
    check_counters();
  endtask

  task automatic end_test(input string name);
    @(negedge clk);
    test_num++;
    assert (exp_q.size() == 0) else begin
      $display("%0d expected words were never returned", exp_q.size());
      errors++;
    end
    check_counters();
    if (errors == errors_before) begin
      passed++;
      $display("test %0d %s: passed", test_num, name);
    end else begin
      failed++;
      $display("test %0d %s: failed with %0d errors", test_num, name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  task automatic preload_memory();
    for (int i = 0; i < rows; i++) begin
      load_en = 1'b1;
      load_addr = i[7:0];
      load_data = shadow_mem[i];
      @(negedge clk);
    end
    load_en = 1'b0;
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout, run still going after %0d cycles", watchdog_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] a;
    clk = 1'b0;
    rst = 1'b1;
    req = 1'b0;
    addr = '0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    stray_en = 1'b0;
    stray_addr = '0;
    seed = 32'h7183;
    errors = 0;
    errors_before = 0;
    passed = 0;
    failed = 0;
    test_num = 0;
    exp_hits = 0;
    exp_misses = 0;
    shadow_valid = '0;
    a = '0;
    for (int i = 0; i < rows; i++) begin
      shadow_mem[i] = {$random(seed), $random(seed)};
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;
    preload_memory();

    // last word of the line, arrives with the final beat
    fetch(32'h01c);
    end_test("cold miss");

    fetch(32'h008);
    fetch(32'h00c);
    end_test("hit timing");

    // line 0 thrashes between tags, line 1 keeps its contents
    fetch(32'h080);
    fetch(32'h020);
    fetch(32'h000);
    fetch(32'h040);
    fetch(32'h000);
    fetch(32'h024);
    fetch(32'h03c);
    end_test("conflict eviction");

    stray_en = 1'b1;
    stray_addr = 32'h100;
    fetch(32'h060);
    stray_en = 1'b0;
    end_test("ignored request");

    // 256 byte window over two cache lines
    repeat (200) begin
      a = $random(seed) & 32'h0fc;
      fetch(a);
    end
    end_test("random sequence");

    // memory image survives, cache state does not
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    shadow_valid = '0;
    exp_hits = 0;
    exp_misses = 0;
    check_counters();
    fetch(a);
    end_test("reset");

    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/icache_top.sv
/*
 * instruction cache subsystem, cache and burst memory on one burst bus
 */
`default_nettype none

`include "icache_consts.svh"

module icache_top
  import icache_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst,
  // processor fetch side
  input  wire logic                      req,
  input  wire logic [`ICACHE_ADDR_W-1:0] addr,
  output logic [`ICACHE_DATA_W-1:0]      data,
  output logic                           data_ready,
  output logic                           busy,
  output logic [31:0]                    hit_count,
  output logic [31:0]                    miss_count,
  // program preload, one row per cycle
  input  wire logic                      load_en,
  input  wire logic [`BRAM_DEPTH_W-1:0]  load_addr,
  input  wire logic [`BRAM_BEAT_W-1:0]   load_data
);

  // line read channel
  burst_bus_if bus ();

  icache u_icache (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .addr       (icache_addr_u'(addr)),
    .data       (data),
    .data_ready (data_ready),
    .busy       (busy),
    .hit_count  (hit_count),
    .miss_count (miss_count),
    .mem        (bus.cache)
  );

  burst_ram #(
    .latency (`BRAM_LATENCY)
  ) u_burst_ram (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus.ram),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

endmodule

`default_nettype wire

// File: hdl/burst_ram.sv
/*
 * burst read memory model, 2 KB of 64-bit rows
 * fixed latency line reads plus a row preload port
 */
`default_nettype none

`include "icache_consts.svh"

module burst_ram #(
  parameter int latency = `BRAM_LATENCY
) (
  input  wire logic                    clk,
  input  wire logic                    rst,
  burst_bus_if.ram                     bus,
  input  wire logic                    load_en,
  input  wire logic [`BRAM_DEPTH_W-1:0] load_addr,
  input  wire logic [`BRAM_BEAT_W-1:0]  load_data
);

  localparam int ROWS = 1 << `BRAM_DEPTH_W;
  localparam int BEAT_IX_W = $clog2(`BRAM_BURST_LEN);
  // countdown starts at latency - 1
  localparam int CNT_W = $clog2(latency + 1);

  logic [`BRAM_BEAT_W-1:0]      mem [ROWS];

  // a burst is outstanding, either counting down or streaming
  logic                         active;
  logic [CNT_W-1:0]             wait_cnt;
  logic [`BRAM_LINE_ADDR_W-1:0] line_q;
  logic [BEAT_IX_W-1:0]         beat_ix;
  logic                         send;

  // a beat goes out on every edge once the countdown is done
  assign send = active && (wait_cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.busy          <= 1'b0;
      bus.rd_data_valid <= 1'b0;
      active            <= 1'b0;
      wait_cnt          <= '0;
      line_q            <= '0;
      beat_ix           <= '0;
    end else begin
      bus.rd_data_valid <= 1'b0;
      if (bus.cmd_en && !bus.busy) begin
        // command accepted
        bus.busy <= 1'b1;
        active   <= 1'b1;
        wait_cnt <= CNT_W'(latency - 1);
        line_q   <= bus.line_addr;
        beat_ix  <= '0;
      end else if (send) begin
        bus.rd_data_valid <= 1'b1;
        beat_ix <= beat_ix + 1'b1;
        if (beat_ix == BEAT_IX_W'(`BRAM_BURST_LEN - 1)) begin
          active <= 1'b0;
        end
      end else if (active) begin
        wait_cnt <= wait_cnt - 1'b1;
      end else if (bus.busy) begin
        // last beat is on the bus this cycle, release afterwards
        bus.busy <= 1'b0;
      end
    end
  end

  // storage and read data
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
    if (send) begin
      bus.rd_data <= mem[{line_q, beat_ix}];
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache.sv
/*
 * direct-mapped instruction cache, two lines of eight words
 * hits answer next cycle, misses fill the whole line over the burst bus
 */
`default_nettype none

`include "icache_consts.svh"

module icache
  import icache_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      req,
  input  wire icache_addr_u              addr,
  output logic [`ICACHE_DATA_W-1:0]      data,
  output logic                           data_ready,
  output logic                           busy,
  output logic [31:0]                    hit_count,
  output logic [31:0]                    miss_count,
  burst_bus_if.cache                     mem
);

  localparam int LINES = 1 << `ICACHE_LINE_IX_W;
  localparam int WORDS = 1 << `ICACHE_WORD_IX_W;
  localparam int DW = `ICACHE_DATA_W;
  localparam int WORDS_PER_BEAT = `BRAM_BEAT_W / `ICACHE_DATA_W;
  // word index bits that select a half inside one beat
  localparam int WB_W = $clog2(WORDS_PER_BEAT);
  localparam int BEAT_IX_W = $clog2(`BRAM_BURST_LEN);
  localparam int LINE_ADDR_W = `BRAM_LINE_ADDR_W;
  // byte address to line address in memory
  localparam int LINE_SHIFT = `ICACHE_WORD_IX_W + `ICACHE_BYTE_OFF_W;

  // tag and valid store
  logic [`ICACHE_TAG_W-1:0]     tag_q [LINES];
  logic [LINES-1:0]             valid_q;

  // line data store
  logic [DW-1:0]                line_data [LINES][WORDS];

  fill_state_e                  state;
  // line being filled and the word the processor is waiting for
  logic [`ICACHE_LINE_IX_W-1:0] fill_line;
  logic [`ICACHE_WORD_IX_W-1:0] fill_word;
  // beat number of the next arriving beat
  logic [BEAT_IX_W-1:0]         beat_ix;
  // first word position covered by the current beat
  logic [`ICACHE_WORD_IX_W-1:0] beat_word;

  logic                         accept;
  logic                         hit;
  logic                         fill_beat;
  logic                         want_beat;

  // a request only counts while not busy
  assign accept = req && !busy;

  assign hit = valid_q[addr.f.line_ix] && (tag_q[addr.f.line_ix] == addr.f.tag);

  // beats only matter while a fill is outstanding
  assign fill_beat = mem.rd_data_valid && ((state == FILL_WAIT) || (state == FILL_RECV));

  assign beat_word = {beat_ix, {WB_W{1'b0}}};

  // this beat carries the requested word
  assign want_beat = (fill_word[`ICACHE_WORD_IX_W-1:WB_W] == beat_ix);

  // control, counters and valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= FILL_IDLE;
      busy       <= 1'b0;
      data_ready <= 1'b0;
      valid_q    <= '0;
      hit_count  <= '0;
      miss_count <= '0;
      mem.cmd_en <= 1'b0;
      fill_line  <= '0;
      fill_word  <= '0;
      beat_ix    <= '0;
    end else begin
      // single cycle strobe by default
      data_ready <= 1'b0;

      if (fill_beat) begin
        beat_ix <= beat_ix + 1'b1;
        if (want_beat) begin
          data_ready <= 1'b1;
        end
      end

      case (state)
        FILL_IDLE: begin
          if (accept && hit) begin
            data_ready <= 1'b1;
            hit_count  <= hit_count + 1'b1;
          end else if (accept) begin
            miss_count <= miss_count + 1'b1;
            busy       <= 1'b1;
            // line is marked valid now, the fill always runs to the end
            valid_q[addr.f.line_ix] <= 1'b1;
            fill_line  <= addr.f.line_ix;
            fill_word  <= addr.f.word_ix;
            beat_ix    <= '0;
            mem.cmd_en <= 1'b1;
            state      <= FILL_ISSUE;
          end
        end
        FILL_ISSUE: begin
          // hold the command until the memory takes it
          if (!mem.busy) begin
            mem.cmd_en <= 1'b0;
            state      <= FILL_WAIT;
          end
        end
        FILL_WAIT: begin
          if (fill_beat) begin
            state <= FILL_RECV;
          end
        end
        FILL_RECV: begin
          if (fill_beat && (beat_ix == BEAT_IX_W'(`BRAM_BURST_LEN - 1))) begin
            busy  <= 1'b0;
            state <= FILL_IDLE;
          end
        end
        default: begin
          state <= FILL_IDLE;
        end
      endcase
    end
  end

  // tags, line data, output word and line address
  always_ff @(posedge clk) begin
    if ((state == FILL_IDLE) && accept && !hit) begin
      tag_q[addr.f.line_ix] <= addr.f.tag;
      mem.line_addr <= LINE_ADDR_W'(addr.raw >> LINE_SHIFT);
    end

    if ((state == FILL_IDLE) && accept && hit) begin
      data <= line_data[addr.f.line_ix][addr.f.word_ix];
    end else if (fill_beat && want_beat) begin
      data <= mem.rd_data[fill_word[WB_W-1:0] * DW +: DW];
    end

    // low half goes to the even word, high half to the odd one
    if (fill_beat) begin
      for (int i = 0; i < WORDS_PER_BEAT; i++) begin
        line_data[fill_line][beat_word + i] <= mem.rd_data[i * DW +: DW];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/burst_bus_if.sv
/*
 * burst read channel between the instruction cache and the burst memory
 */
`default_nettype none

`include "icache_consts.svh"

interface burst_bus_if;

  // command side, driven by the cache
  logic                         cmd_en;
  logic [`BRAM_LINE_ADDR_W-1:0] line_addr;

  // response side, driven by the memory
  logic                         busy;
  logic [`BRAM_BEAT_W-1:0]      rd_data;
  logic                         rd_data_valid;

  // cache issues line reads, cannot stall the beats
  modport cache (output cmd_en, line_addr, input busy, rd_data, rd_data_valid);

  // memory accepts one command at a time and streams the line back
  modport ram (input cmd_en, line_addr, output busy, rd_data, rd_data_valid);

endinterface

`default_nettype wire

// File: hdl/icache_pkg.sv
/*
 * icache types: request address views and line-fill controller states
 */
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  // |tag|line|word|00| as seen by the lookup logic
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]      tag;
    logic [`ICACHE_LINE_IX_W-1:0]  line_ix;
    logic [`ICACHE_WORD_IX_W-1:0]  word_ix;
    logic [`ICACHE_BYTE_OFF_W-1:0] byte_off;
  } icache_addr_fields_t;

  // raw view is used when forming the memory line address
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    icache_addr_fields_t       f;
  } icache_addr_u;

  // idle, waiting for command accept, waiting for first beat, taking beats
  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_ISSUE,
    FILL_WAIT,
    FILL_RECV
  } fill_state_e;

endpackage

`default_nettype wire

// File: hdl/icache_consts.svh
/*
 * icache constants: cache geometry, burst memory size and read latency
 */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// byte address and instruction word
`define ICACHE_ADDR_W 32
`define ICACHE_DATA_W 32

// 8 words per line, 2 lines
`define ICACHE_WORD_IX_W 3
`define ICACHE_LINE_IX_W 1

// addresses are word aligned, low two bits ignored
`define ICACHE_BYTE_OFF_W 2

// whatever is left above line index, word index and byte offset
`define ICACHE_TAG_W \
  (`ICACHE_ADDR_W - `ICACHE_LINE_IX_W - `ICACHE_WORD_IX_W - `ICACHE_BYTE_OFF_W)

// one beat is two instruction words, four beats fill one 32 byte line
`define BRAM_BEAT_W 64
`define BRAM_BURST_LEN 4

// 256 rows of 8 bytes, 2 KB total
`define BRAM_DEPTH_W 8
// row address without the beat index inside a line
`define BRAM_LINE_ADDR_W (`BRAM_DEPTH_W - 2)

// cycles from an accepted command to the first beat
`define BRAM_LATENCY 2

`endif
